//--- logic/vector_unit_params.svh
`ifndef VECTOR_UNIT_PARAMS_SVH
`define VECTOR_UNIT_PARAMS_SVH

// width of one packed operand word
`define VMUL_DATA_W 32

// register stages inside each lane multiplier
`define VMUL_MULT_STAGES 2

// enabled cycles from an accepted input to its result:
// the multiplier stages plus the result stage register
`define VMUL_LATENCY (`VMUL_MULT_STAGES + 1)

`endif

//--- logic/vector_unit_pkg.sv
`include "vector_unit_params.svh"

package vector_unit_pkg;

    // lane split of one operand word
    typedef enum logic {
        BIT8  = 1'b0,   // four 8 bit lanes
        BIT16 = 1'b1    // two 16 bit lanes
    } esize_t;

    // operand word, read either as four bytes or two halfwords
    typedef union packed {
        logic [3:0][`VMUL_DATA_W/4-1:0] vect4;
        logic [1:0][`VMUL_DATA_W/2-1:0] vect2;
    } vector_t;

    // result word, each lane is twice the operand lane width
    typedef union packed {
        logic [3:0][`VMUL_DATA_W/2-1:0] vect4;  // four 16 bit products
        logic [1:0][`VMUL_DATA_W-1:0]   vect2;  // two 32 bit products
    } vmul_vector_t;

endpackage : vector_unit_pkg

//--- logic/vmul_operand_if.sv
interface vmul_operand_if;

    vector_unit_pkg::vector_t multiplicand;  // lane magnitudes
    vector_unit_pkg::vector_t multiplier;    // lane magnitudes
    logic [3:0]               negate_mask;   // one bit per 8 bit lane, bits 1:0 for 16 bit
    vector_unit_pkg::esize_t  element_size;
    logic                     valid;

    modport producer (
        output multiplicand,
        output multiplier,
        output negate_mask,
        output element_size,
        output valid
    );

    modport consumer (
        input multiplicand,
        input multiplier,
        input negate_mask,
        input element_size,
        input valid
    );

endinterface : vmul_operand_if

//--- logic/vector_operand_conditioner.sv
module vector_operand_conditioner (
    vmul_operand_if.producer         bus_o,

    input  vector_unit_pkg::vector_t multiplicand_i,
    input  vector_unit_pkg::vector_t multiplier_i,
    input  vector_unit_pkg::esize_t  element_size_i,
    input  logic [1:0]               is_signed_i,    // bit 0 multiplicand, bit 1 multiplier
    input  logic                     data_valid_i
);

    // the multipliers are unsigned, so negative signed lanes are
    // replaced by their magnitude and the product sign is kept aside
    always_comb begin : abs_value
        logic [3:0] mcand_neg;
        logic [3:0] mplier_neg;

        bus_o.multiplicand = multiplicand_i;  // positive lanes pass as is
        bus_o.multiplier   = multiplier_i;
        mcand_neg          = '0;
        mplier_neg         = '0;

        if (element_size_i == vector_unit_pkg::BIT16) begin
            for (int i = 0; i < 2; i++) begin
                mcand_neg[i]  = multiplicand_i.vect2[i][15] & is_signed_i[0];
                mplier_neg[i] = multiplier_i.vect2[i][15] & is_signed_i[1];

                if (mcand_neg[i]) begin
                    bus_o.multiplicand.vect2[i] = -multiplicand_i.vect2[i];
                end
                if (mplier_neg[i]) begin
                    bus_o.multiplier.vect2[i] = -multiplier_i.vect2[i];
                end
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                mcand_neg[i]  = multiplicand_i.vect4[i][7] & is_signed_i[0];
                mplier_neg[i] = multiplier_i.vect4[i][7] & is_signed_i[1];

                if (mcand_neg[i]) begin
                    bus_o.multiplicand.vect4[i] = -multiplicand_i.vect4[i];
                end
                if (mplier_neg[i]) begin
                    bus_o.multiplier.vect4[i] = -multiplier_i.vect4[i];
                end
            end
        end

        // product is negative only when exactly one side was negative
        bus_o.negate_mask = mcand_neg ^ mplier_neg;
    end : abs_value

    assign bus_o.element_size = element_size_i;
    assign bus_o.valid        = data_valid_i;

endmodule : vector_operand_conditioner

//--- logic/pipelined_array_multiplier.sv
`include "vector_unit_params.svh"

module pipelined_array_multiplier #(
    parameter int WIDTH = 8
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               clk_en_i,

    input  logic [WIDTH-1:0]   multiplicand_i,
    input  logic [WIDTH-1:0]   multiplier_i,

    output logic [2*WIDTH-1:0] product_o
);

    localparam int STAGES = `VMUL_MULT_STAGES;
    localparam int ROWS   = (WIDTH + STAGES - 1) / STAGES;  // partial product rows per stage

    // operands and running sum as seen at the input of each stage
    logic [WIDTH-1:0]   mcand_d  [STAGES];
    logic [WIDTH-1:0]   mplier_d [STAGES];
    logic [2*WIDTH-1:0] acc_d    [STAGES];

    // operand copies carried along to the later stages
    logic [WIDTH-1:0]   mcand_q  [1:STAGES-1];
    logic [WIDTH-1:0]   mplier_q [1:STAGES-1];

    logic [2*WIDTH-1:0] pp_row   [WIDTH];   // shifted partial products
    logic [2*WIDTH-1:0] acc_next [STAGES];
    logic [2*WIDTH-1:0] acc_q    [STAGES];

    always_comb begin : stage_inputs
        mcand_d[0]  = multiplicand_i;
        mplier_d[0] = multiplier_i;
        acc_d[0]    = '0;
        for (int s = 1; s < STAGES; s++) begin
            mcand_d[s]  = mcand_q[s];
            mplier_d[s] = mplier_q[s];
            acc_d[s]    = acc_q[s-1];
        end
    end : stage_inputs

    // row r belongs to stage r / ROWS and uses that stage's operand copy
    always_comb begin : partial_products
        for (int r = 0; r < WIDTH; r++) begin
            pp_row[r] = mplier_d[r/ROWS][r] ? ({{WIDTH{1'b0}}, mcand_d[r/ROWS]} << r) : '0;
        end
    end : partial_products

    always_comb begin : row_accumulate
        for (int s = 0; s < STAGES; s++) begin
            acc_next[s] = acc_d[s];
            for (int r = s * ROWS; r < (s + 1) * ROWS && r < WIDTH; r++) begin
                acc_next[s] = acc_next[s] + pp_row[r];
            end
        end
    end : row_accumulate

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < STAGES; s++) begin
                acc_q[s] <= '0;
            end
        end else if (clk_en_i) begin
            for (int s = 0; s < STAGES; s++) begin
                acc_q[s] <= acc_next[s];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            for (int s = 1; s < STAGES; s++) begin
                mcand_q[s]  <= mcand_d[s-1];
                mplier_q[s] <= mplier_d[s-1];
            end
        end
    end

    assign product_o = acc_q[STAGES-1];  // last stage holds the full sum

endmodule : pipelined_array_multiplier

//--- logic/vector_multiplier.sv
`include "vector_unit_params.svh"

module vector_multiplier (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          clk_en_i,

    vmul_operand_if.consumer              bus_i,

    output vector_unit_pkg::vmul_vector_t result_o,
    output logic                          data_valid_o
);

    localparam int STAGES = `VMUL_MULT_STAGES;

    vector_unit_pkg::vmul_vector_t prod_8bit;   // four byte lane products
    vector_unit_pkg::vmul_vector_t prod_16bit;  // two halfword lane products

    for (genvar i = 0; i < 4; i++) begin : g_mult8
        pipelined_array_multiplier #(
            .WIDTH (8)
        ) mult8_i (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .clk_en_i       (clk_en_i),
            .multiplicand_i (bus_i.multiplicand.vect4[i]),
            .multiplier_i   (bus_i.multiplier.vect4[i]),
            .product_o      (prod_8bit.vect4[i])
        );
    end

    for (genvar i = 0; i < 2; i++) begin : g_mult16
        pipelined_array_multiplier #(
            .WIDTH (16)
        ) mult16_i (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .clk_en_i       (clk_en_i),
            .multiplicand_i (bus_i.multiplicand.vect2[i]),
            .multiplier_i   (bus_i.multiplier.vect2[i]),
            .product_o      (prod_16bit.vect2[i])
        );
    end

    // side information travels alongside the multiplier stages
    vector_unit_pkg::esize_t esize_pipe [STAGES];
    logic [3:0]              mask_pipe  [STAGES];

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            esize_pipe[0] <= bus_i.element_size;
            mask_pipe[0]  <= bus_i.negate_mask;
            for (int s = 1; s < STAGES; s++) begin
                esize_pipe[s] <= esize_pipe[s-1];
                mask_pipe[s]  <= mask_pipe[s-1];
            end
        end
    end

    vector_unit_pkg::vmul_vector_t product_q;
    vector_unit_pkg::esize_t       esize_q;
    logic [3:0]                    mask_q;

    // result stage, picks the product set for this element size
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            product_q <= (esize_pipe[STAGES-1] == vector_unit_pkg::BIT8) ? prod_8bit : prod_16bit;
            esize_q   <= esize_pipe[STAGES-1];
            mask_q    <= mask_pipe[STAGES-1];
        end
    end

    always_comb begin : sign_correction
        result_o = product_q;
        if (esize_q == vector_unit_pkg::BIT16) begin
            for (int i = 0; i < 2; i++) begin
                if (mask_q[i]) begin
                    result_o.vect2[i] = -product_q.vect2[i];
                end
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (mask_q[i]) begin
                    result_o.vect4[i] = -product_q.vect4[i];
                end
            end
        end
    end : sign_correction

    logic [`VMUL_LATENCY-1:0] valid_pipe;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_pipe <= '0;
        end else if (clk_en_i) begin
            valid_pipe <= {valid_pipe[`VMUL_LATENCY-2:0], bus_i.valid};
        end
    end

    assign data_valid_o = valid_pipe[`VMUL_LATENCY-1];

endmodule : vector_multiplier

//--- logic/vector_multiply_unit.sv
module vector_multiply_unit (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          clk_en_i,   // low freezes the whole pipeline

    input  vector_unit_pkg::vector_t      multiplicand_i,
    input  vector_unit_pkg::vector_t      multiplier_i,
    input  vector_unit_pkg::esize_t       element_size_i,
    input  logic [1:0]                    is_signed_i,
    input  logic                          data_valid_i,

    output vector_unit_pkg::vmul_vector_t result_o,
    output logic                          data_valid_o
);

    // conditioned operands, same cycle as the inputs
    vmul_operand_if operand_bus ();

    vector_operand_conditioner conditioner_i (
        .bus_o          (operand_bus.producer),
        .multiplicand_i (multiplicand_i),
        .multiplier_i   (multiplier_i),
        .element_size_i (element_size_i),
        .is_signed_i    (is_signed_i),
        .data_valid_i   (data_valid_i)
    );

    vector_multiplier multiplier_i_0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (clk_en_i),
        .bus_i        (operand_bus.consumer),
        .result_o     (result_o),
        .data_valid_o (data_valid_o)
    );

endmodule : vector_multiply_unit

//--- verif/vmul_assertions.sv
`include "vector_unit_params.svh"

module vmul_assertions (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        clk_en_i,
    input  logic        in_valid_i,
    input  logic        out_valid_i,
    input  logic [63:0] result_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int                       fail_count = 0;
    logic [`VMUL_LATENCY-1:0] accepted_hist;  // accepted inputs, one bit per enabled cycle

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            accepted_hist <= '0;
        end else if (clk_en_i) begin
            accepted_hist <= {accepted_hist[`VMUL_LATENCY-2:0], in_valid_i};
        end
    end

    valid_low_after_reset : assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
        else begin
            fail_count++;
            $error("data_valid_o high in the cycle after reset");
        end

    valid_follows_input : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i == accepted_hist[`VMUL_LATENCY-1])
        else begin
            fail_count++;
            $error("data_valid_o does not follow data_valid_i by the unit latency");
        end

    hold_when_disabled : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !clk_en_i |=> $stable(out_valid_i) && $stable(result_i))
        else begin
            fail_count++;
            $error("outputs changed while clk_en_i was low");
        end

endmodule : vmul_assertions

//--- verif/vmul_checker.sv
module vmul_checker (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        clk_en_i,
    input  logic        dut_valid_i,
    input  logic [63:0] dut_result_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [63:0] expected_q [$];  // oldest operation first
    logic [63:0] expected;
    int          pass_count  = 0;
    int          error_count = 0;
    int          test_count  = 0;

    // each lane is sign or zero extended and multiplied modulo the product width
    function automatic logic [63:0] model_product(input logic [31:0] a, input logic [31:0] b,
                                                  input vector_unit_pkg::esize_t esize,
                                                  input logic [1:0] sgn);
        logic [63:0] res;
        logic [31:0] ax;
        logic [31:0] bx;
        res = '0;
        if (esize == vector_unit_pkg::BIT16) begin
            for (int i = 0; i < 2; i++) begin
                ax = {{16{sgn[0] & a[16*i+15]}}, a[16*i +: 16]};
                bx = {{16{sgn[1] & b[16*i+15]}}, b[16*i +: 16]};
                res[32*i +: 32] = ax * bx;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                ax = {{24{sgn[0] & a[8*i+7]}}, a[8*i +: 8]};
                bx = {{24{sgn[1] & b[8*i+7]}}, b[8*i +: 8]};
                res[16*i +: 16] = 16'(ax * bx);
            end
        end
        return res;
    endfunction

    task automatic push_expected(input logic [63:0] value);
        expected_q.push_back(value);
    endtask

    function automatic int pending();
        return expected_q.size();
    endfunction

    // outputs are settled mid cycle; a held result counts once, on its enabled edge
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            if (expected_q.size() != 0) begin
                $display("reset seen, %0d operations in flight dropped", expected_q.size());
            end
            expected_q.delete();
        end else if (clk_en_i && dut_valid_i === 1'b1) begin
            test_count++;
            if (expected_q.size() == 0) begin
                error_count++;
                $display("test %0d: valid output with no operation outstanding", test_count);
            end else begin
                expected = expected_q.pop_front();
                if (dut_result_i === expected) begin
                    pass_count++;
                    $display("test %0d passed: result_o = 0x%h", test_count, dut_result_i);
                end else begin
                    error_count++;
                    $display("MISMATCH result_o test %0d: expected 0x%h actual 0x%h",
                             test_count, expected, dut_result_i);
                end
            end
        end
    end

    task automatic report();
        if (expected_q.size() != 0) begin
            error_count++;
            $display("%0d expected results never arrived", expected_q.size());
        end
        $display("passed: %0d  failed: %0d", pass_count, error_count);
    endtask

endmodule : vmul_checker

//--- verif/vmul_tb.sv
`include "vector_unit_params.svh"

module vmul_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int RANDOM_ROWS  = 16;
    localparam vector_unit_pkg::esize_t E8  = vector_unit_pkg::BIT8;
    localparam vector_unit_pkg::esize_t E16 = vector_unit_pkg::BIT16;

    // what happens during the gap cycles after a row
    typedef enum int {GAP_IDLE, GAP_STALL, GAP_RESET} gap_kind_t;

    typedef struct {
        logic [31:0]             mcand;
        logic [31:0]             mplier;
        vector_unit_pkg::esize_t esize;
        logic [1:0]              sgn;
        logic [63:0]             expected;
        int                      gap;
        gap_kind_t               kind;
    } row_t;

    logic                          clk_i;
    logic                          rst_n_i;
    logic                          clk_en_i;
    vector_unit_pkg::vector_t      multiplicand_i;
    vector_unit_pkg::vector_t      multiplier_i;
    vector_unit_pkg::esize_t       element_size_i;
    logic [1:0]                    is_signed_i;
    logic                          data_valid_i;
    vector_unit_pkg::vmul_vector_t result_o;
    logic                          data_valid_o;

    row_t   rows [$];
    integer seed;
    longint limit_ns;

    vector_multiply_unit vector_multiply_unit_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .clk_en_i       (clk_en_i),
        .multiplicand_i (multiplicand_i),
        .multiplier_i   (multiplier_i),
        .element_size_i (element_size_i),
        .is_signed_i    (is_signed_i),
        .data_valid_i   (data_valid_i),
        .result_o       (result_o),
        .data_valid_o   (data_valid_o)
    );

    vmul_checker checker_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (clk_en_i),
        .dut_valid_i  (data_valid_o),
        .dut_result_i (result_o)
    );

    bind vector_multiply_unit vmul_assertions assertions_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clk_en_i    (clk_en_i),
        .in_valid_i  (data_valid_i),
        .out_valid_i (data_valid_o),
        .result_i    (result_o)
    );

    task automatic add_row(input logic [31:0] mcand, input logic [31:0] mplier,
                           input vector_unit_pkg::esize_t esize, input logic [1:0] sgn,
                           input logic [63:0] expected, input int gap, input gap_kind_t kind);
        row_t r;
        r = '{mcand, mplier, esize, sgn, expected, gap, kind};
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0]             mcand;
        logic [31:0]             mplier;
        vector_unit_pkg::esize_t esize;
        logic [1:0]              sgn;
        // unsigned bytes
        add_row(32'hFFFF_FFFF, 32'hFFFF_FFFF, E8, 2'b00, 64'hFE01_FE01_FE01_FE01, 1, GAP_IDLE);
        add_row(32'h0102_0304, 32'h0506_0708, E8, 2'b00, 64'h0005_000C_0015_0020, 0, GAP_IDLE);
        add_row(32'h807F_1000, 32'h027F_10FF, E8, 2'b00, 64'h0100_3F01_0100_0000, 1, GAP_IDLE);
        // signed halfwords
        add_row(32'h8000_FFFF, 32'h8000_0003, E16, 2'b11, 64'h4000_0000_FFFF_FFFD, 0, GAP_IDLE);
        add_row(32'h0064_FF38, 32'hFF9C_FF38, E16, 2'b11, 64'hFFFF_D8F0_0000_9C40, 0, GAP_IDLE);
        add_row(32'h7FFF_8000, 32'h7FFF_7FFF, E16, 2'b11, 64'h3FFF_0001_C000_8000, 2, GAP_IDLE);
        add_row(32'h80FF_7FF6, 32'h8001_8105, E8, 2'b11, 64'h4000_FFFF_C0FF_FFCE, 1, GAP_IDLE);
        // mixed signedness
        add_row(32'h8080_8080, 32'hFFFF_FFFF, E8, 2'b01, 64'h8080_8080_8080_8080, 0, GAP_IDLE);
        add_row(32'hFFFF_0100, 32'h8001_FF80, E8, 2'b10, 64'h8080_00FF_FFFF_0000, 0, GAP_IDLE);
        add_row(32'h8000_8000, 32'hFFFF_0001, E16, 2'b01, 64'h8000_8000_FFFF_8000, 0, GAP_IDLE);
        add_row(32'hFFFF_0002, 32'h8000_FFFF, E16, 2'b10, 64'h8000_8000_FFFF_FFFE, 3, GAP_IDLE);
        // two ops in flight and then flushed by reset
        add_row(32'h1111_1111, 32'h1111_1111, E8, 2'b00, 64'h0121_0121_0121_0121, 0, GAP_IDLE);
        add_row(32'h0002_0003, 32'h0004_0005, E16, 2'b00, 64'h0000_0008_0000_000F, 4, GAP_RESET);
        // three ops in flight across a stall
        add_row(32'hFFFF_FFFF, 32'hFFFF_0002, E16, 2'b00, 64'hFFFE_0001_0001_FFFE, 0, GAP_IDLE);
        add_row(32'h0A0B_0C0D, 32'h0202_0202, E8, 2'b00, 64'h0014_0016_0018_001A, 0, GAP_IDLE);
        add_row(32'hFEFE_0202, 32'hFD03_FD03, E8, 2'b11, 64'h0006_FFFA_FFFA_0006, 5, GAP_STALL);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            mcand  = $random(seed);
            mplier = $random(seed);
            esize  = ($random(seed) & 1) ? E16 : E8;
            sgn    = 2'($random(seed));
            add_row(mcand, mplier, esize, sgn, checker_i.model_product(mcand, mplier, esize, sgn),
                    {$random(seed)} % 3, GAP_IDLE);
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk_i);
        multiplicand_i <= r.mcand;
        multiplier_i   <= r.mplier;
        element_size_i <= r.esize;
        is_signed_i    <= r.sgn;
        data_valid_i   <= 1'b1;
        clk_en_i       <= 1'b1;
        rst_n_i        <= 1'b1;
        checker_i.push_expected(r.expected);
        repeat (r.gap) begin
            @(posedge clk_i);
            data_valid_i <= 1'b0;
            clk_en_i     <= (r.kind != GAP_STALL);
            rst_n_i      <= (r.kind != GAP_RESET);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        seed           = 32'h900dbcbb;
        rst_n_i        = 1'b0;
        clk_en_i       = 1'b1;
        data_valid_i   = 1'b0;
        multiplicand_i = '0;
        multiplier_i   = '0;
        element_size_i = E8;
        is_signed_i    = 2'b00;
        build_table();

        limit_ns = 0;
        foreach (rows[i]) begin
            limit_ns += rows[i].gap + `VMUL_LATENCY + 1;
        end
        limit_ns = 2 * limit_ns * CLK_PERIOD;

        fork
            begin : watchdog
                #(limit_ns);
                $display("timeout: results still missing after %0d ns", limit_ns);
                $display("Done: errors found");
                $finish;
            end
        join_none

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        @(posedge clk_i);
        data_valid_i <= 1'b0;

        while (checker_i.pending() != 0) begin
            @(posedge clk_i);
        end
        repeat (`VMUL_LATENCY + 1) @(posedge clk_i);  // catch stray pulses
        checker_i.report();

        if (checker_i.error_count == 0 && vector_multiply_unit_i.assertions_i.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : vmul_tb

//--- flist.f
+incdir+logic
logic/vector_unit_pkg.sv
logic/vmul_operand_if.sv
logic/vector_operand_conditioner.sv
logic/pipelined_array_multiplier.sv
logic/vector_multiplier.sv
logic/vector_multiply_unit.sv
verif/vmul_assertions.sv
verif/vmul_checker.sv
verif/vmul_tb.sv

//--- Bender.yml
package:
  name: vector_multiply_unit

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/vector_unit_pkg.sv
      - logic/vmul_operand_if.sv
      - logic/vector_operand_conditioner.sv
      - logic/pipelined_array_multiplier.sv
      - logic/vector_multiplier.sv
      - logic/vector_multiply_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/vmul_assertions.sv
      - verif/vmul_checker.sv
      - verif/vmul_tb.sv
